// ==== cpuPkg.sv ====
`default_nettype none

package cpuPkg;

	// datapath sizes
	localparam int dataWidth = 16;
	localparam int regAddrWidth = 3;
	localparam int numRegs = 8;
	// shift amount comes from imm[3:0]
	localparam int shiftCountWidth = 4;

	// opcodes, instruction bits 15:11
	localparam logic [4:0] opAlu = 5'b11011;
	localparam logic [4:0] opAddi = 5'b01000;
	localparam logic [4:0] opAndni = 5'b01011;
	localparam logic [4:0] opSlli = 5'b10100;
	localparam logic [4:0] opSrli = 5'b10110;
	localparam logic [4:0] opLbi = 5'b11000;
	localparam logic [4:0] opSlbi = 5'b10010;
	localparam logic [4:0] opNop = 5'b00001;
	localparam logic [4:0] opHalt = 5'b00000;

	// alu function chosen by decode
	typedef enum logic [3:0] {
		aluAdd, aluSub, aluAnd, aluXor, aluAndn,
		aluPassImm, aluSlbi, aluShl, aluShr
	} aluOp;

	// immediate extension modes
	typedef enum logic [1:0] {
		extSext5, extZext5, extSext8, extZext8
	} extSel;

	// which instruction field names the destination
	typedef enum logic [1:0] {
		destRd, destRt, destRs
	} destSelect;

	// control word, 12 bits
	typedef struct packed {
		logic regWrite;
		logic isShift;
		logic isHalt;
		logic illegal;
		destSelect destSel;
		extSel immSel;
		aluOp aluCtl;
	} ctrlWord;

endpackage

`default_nettype wire

// ==== decodeIf.sv ====
`timescale 1ns/10ps
`default_nettype none

interface decodeIf;

	// register operands, Rs on A
	logic [cpuPkg::dataWidth-1:0] A;
	logic [cpuPkg::dataWidth-1:0] B;
	// extended immediate
	logic [cpuPkg::dataWidth-1:0] imm;
	cpuPkg::ctrlWord ctrl;
	// writeback target
	logic [cpuPkg::regAddrWidth-1:0] destReg;
	logic [cpuPkg::shiftCountWidth-1:0] shamt;

	modport producer (output A, B, imm, ctrl, destReg, shamt);
	modport execute (input A, B, imm, ctrl, destReg, shamt);
	// sequencer only steers on control and shift length
	modport sequencer (input ctrl, shamt);

endinterface

`default_nettype wire

// ==== controlDecode.sv ====
`timescale 1ns/10ps
`default_nettype none

module controlDecode (
	input logic [4:0] opCode,
	input logic [1:0] funct,
	output cpuPkg::ctrlWord ctrl
);

	always_comb begin
		// all zero means no write, Rd, sext5, add
		ctrl = '0;
		case (opCode)
			cpuPkg::opAlu: begin
				ctrl.regWrite = 1'b1;
				ctrl.destSel = cpuPkg::destRd;
				// funct picks the R-type operation
				case (funct)
					2'b00: ctrl.aluCtl = cpuPkg::aluAdd;
					2'b01: ctrl.aluCtl = cpuPkg::aluSub;
					2'b10: ctrl.aluCtl = cpuPkg::aluAnd;
					default: ctrl.aluCtl = cpuPkg::aluXor;
				endcase
			end
			cpuPkg::opAddi: begin
				ctrl.regWrite = 1'b1;
				ctrl.destSel = cpuPkg::destRt;
				ctrl.immSel = cpuPkg::extSext5;
				ctrl.aluCtl = cpuPkg::aluAdd;
			end
			cpuPkg::opAndni: begin
				ctrl.regWrite = 1'b1;
				ctrl.destSel = cpuPkg::destRt;
				ctrl.immSel = cpuPkg::extZext5;
				ctrl.aluCtl = cpuPkg::aluAndn;
			end
			cpuPkg::opSlli, cpuPkg::opSrli: begin
				ctrl.regWrite = 1'b1;
				ctrl.isShift = 1'b1;
				ctrl.destSel = cpuPkg::destRt;
				// bit 1 of the opcode tells right from left
				ctrl.aluCtl = opCode[1] ? cpuPkg::aluShr : cpuPkg::aluShl;
			end
			cpuPkg::opLbi: begin
				ctrl.regWrite = 1'b1;
				ctrl.destSel = cpuPkg::destRs;
				ctrl.immSel = cpuPkg::extSext8;
				ctrl.aluCtl = cpuPkg::aluPassImm;
			end
			cpuPkg::opSlbi: begin
				ctrl.regWrite = 1'b1;
				ctrl.destSel = cpuPkg::destRs;
				ctrl.immSel = cpuPkg::extZext8;
				ctrl.aluCtl = cpuPkg::aluSlbi;
			end
			cpuPkg::opNop: begin
				// retires quietly
				ctrl.regWrite = 1'b0;
			end
			cpuPkg::opHalt: ctrl.isHalt = 1'b1;
			default: ctrl.illegal = 1'b1;
		endcase
	end

endmodule

`default_nettype wire

// ==== regFile.sv ====
`timescale 1ns/10ps
`default_nettype none

module regFile (
	input logic clk,
	input logic rst,
	input logic [cpuPkg::regAddrWidth-1:0] readReg1Sel,
	input logic [cpuPkg::regAddrWidth-1:0] readReg2Sel,
	input logic [cpuPkg::regAddrWidth-1:0] writeRegSel,
	input logic [cpuPkg::dataWidth-1:0] writeData,
	input logic writeEn,
	output logic [cpuPkg::dataWidth-1:0] readData1,
	output logic [cpuPkg::dataWidth-1:0] readData2
);

	logic [cpuPkg::dataWidth-1:0] regs [cpuPkg::numRegs];

	// registers start at zero
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < cpuPkg::numRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn) begin
			regs[writeRegSel] <= writeData;
		end
	end

	// asynchronous reads
	// writeback always lands before the next decode
	assign readData1 = regs[readReg1Sel];
	assign readData2 = regs[readReg2Sel];

endmodule

`default_nettype wire

// ==== immExtend.sv ====
`timescale 1ns/10ps
`default_nettype none

module immExtend (
	input logic [7:0] immBits,
	input cpuPkg::extSel sel,
	output logic [cpuPkg::dataWidth-1:0] imm
);

	localparam int w = cpuPkg::dataWidth;

	always_comb begin
		case (sel)
			// imm5 modes use bits 4:0
			cpuPkg::extSext5: imm = {{(w-5){immBits[4]}}, immBits[4:0]};
			cpuPkg::extZext5: imm = {{(w-5){1'b0}}, immBits[4:0]};
			// imm8 modes use the whole low byte
			cpuPkg::extSext8: imm = {{(w-8){immBits[7]}}, immBits};
			default: imm = {{(w-8){1'b0}}, immBits};
		endcase
	end

endmodule

`default_nettype wire

// ==== decodeInstruction.sv ====
`timescale 1ns/10ps
`default_nettype none

module decodeInstruction (
	input logic clk,
	input logic rst,
	input logic [cpuPkg::dataWidth-1:0] instruction,
	input logic [cpuPkg::dataWidth-1:0] writeData,
	input logic [cpuPkg::regAddrWidth-1:0] writeRegister,
	input logic writeEn,
	decodeIf.producer dec
);

	cpuPkg::ctrlWord ctrl;
	logic [cpuPkg::regAddrWidth-1:0] rs;
	logic [cpuPkg::regAddrWidth-1:0] rt;
	logic [cpuPkg::regAddrWidth-1:0] rd;
	logic [cpuPkg::regAddrWidth-1:0] read2Sel;

	// instruction fields
	assign rs = instruction[10:8];
	assign rt = instruction[7:5];
	assign rd = instruction[4:2];

	controlDecode u_controlDecode (
		.opCode(instruction[15:11]),
		.funct(instruction[1:0]),
		.ctrl(ctrl)
	);
	assign dec.ctrl = ctrl;

	// SLBI shifts Rs, so port 2 reads Rs too
	assign read2Sel = (ctrl.aluCtl == cpuPkg::aluSlbi) ? rs : rt;

	regFile u_regFile (
		.clk(clk), .rst(rst),
		.readReg1Sel(rs), .readReg2Sel(read2Sel),
		.writeRegSel(writeRegister), .writeData(writeData), .writeEn(writeEn),
		.readData1(dec.A), .readData2(dec.B)
	);

	immExtend u_immExtend (
		.immBits(instruction[7:0]),
		.sel(ctrl.immSel),
		.imm(dec.imm)
	);

	// destination by format
	always_comb begin
		case (ctrl.destSel)
			cpuPkg::destRt: dec.destReg = rt;
			cpuPkg::destRs: dec.destReg = rs;
			default: dec.destReg = rd;
		endcase
	end

	// shift amount from imm[3:0]
	assign dec.shamt = instruction[3:0];

endmodule

`default_nettype wire

// ==== execUnit.sv ====
`timescale 1ns/10ps
`default_nettype none

module execUnit (
	input logic clk,
	input logic rst,
	input logic start,
	input logic step,
	decodeIf.execute dec,
	output logic [cpuPkg::dataWidth-1:0] result
);

	logic [cpuPkg::dataWidth-1:0] operand;
	logic [cpuPkg::dataWidth-1:0] aluValue;

	// R-type uses Rt, every I-type uses the immediate
	assign operand = (dec.ctrl.destSel == cpuPkg::destRd) ? dec.B : dec.imm;

	always_comb begin
		case (dec.ctrl.aluCtl)
			cpuPkg::aluAdd: aluValue = dec.A + operand;
			cpuPkg::aluSub: aluValue = dec.A - operand;
			cpuPkg::aluAnd: aluValue = dec.A & operand;
			cpuPkg::aluXor: aluValue = dec.A ^ operand;
			cpuPkg::aluAndn: aluValue = dec.A & ~operand;
			cpuPkg::aluPassImm: aluValue = dec.imm;
			// B holds Rs here
			cpuPkg::aluSlbi: aluValue = {dec.B[7:0], 8'h00} | dec.imm;
			default: aluValue = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			result <= '0;
		end else if (start) begin
			// shifts begin from Rs and move one bit per step
			result <= dec.ctrl.isShift ? dec.A : aluValue;
		end else if (step) begin
			if (dec.ctrl.aluCtl == cpuPkg::aluShr) begin
				result <= {1'b0, result[cpuPkg::dataWidth-1:1]};
			end else begin
				result <= {result[cpuPkg::dataWidth-2:0], 1'b0};
			end
		end
	end

	// steps are only ever issued for a decoded shift
	stepOnlyOnShift: assert property (@(posedge clk) disable iff (rst)
		step |-> dec.ctrl.isShift);

endmodule

`default_nettype wire

// ==== shiftCounter.sv ====
`timescale 1ns/10ps
`default_nettype none

module shiftCounter (
	input logic clk,
	input logic rst,
	input logic load,
	input logic [cpuPkg::shiftCountWidth-1:0] amount,
	input logic step,
	output logic done
);

	// steps still to go
	logic [cpuPkg::shiftCountWidth-1:0] remaining;

	always_ff @(posedge clk) begin
		if (rst) begin
			remaining <= '0;
		end else if (load) begin
			remaining <= amount;
		end else if (step) begin
			remaining <= remaining - {{(cpuPkg::shiftCountWidth-1){1'b0}}, 1'b1};
		end
	end

	// zero amount is finished at once
	assign done = (remaining == '0);

	// sequencer must stop stepping once the count runs out
	noStepWhenDone: assert property (@(posedge clk) disable iff (rst) step |-> !done);

endmodule

`default_nettype wire

// ==== coreSequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module coreSequencer (
	input logic clk,
	input logic rst,
	input logic instrReq,
	output logic instrAck,
	output logic latchInstr,
	decodeIf.sequencer seq,
	output logic start,
	output logic step,
	output logic load,
	input logic shiftDone,
	output logic writeEn,
	output logic err,
	output logic halt
);

	typedef enum logic [2:0] {
		stIdle, stDecode, stExecute, stShift, stWrite, stRelease, stHalted
	} seqState;

	seqState state;
	seqState nextState;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= stIdle;
			instrAck <= 1'b0;
			halt <= 1'b0;
		end else begin
			state <= nextState;
			// ack up on the latch, down once retired and req is gone
			if (state == stIdle && instrReq) begin
				instrAck <= 1'b1;
			end else if (state == stRelease && !instrReq) begin
				instrAck <= 1'b0;
			end
			// sticky until reset
			if (state == stWrite && seq.ctrl.isHalt) begin
				halt <= 1'b1;
			end
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			stIdle: if (instrReq) nextState = stDecode;
			stDecode: nextState = stExecute;
			// every op passes through shift where non-shifts find the count at zero
			stExecute: nextState = stShift;
			stShift: if (shiftDone) nextState = stWrite;
			stWrite: nextState = stRelease;
			stRelease: if (!instrReq) nextState = halt ? stHalted : stIdle;
			default: nextState = stHalted;
		endcase
	end

	assign latchInstr = (state == stIdle) && instrReq;
	assign start = (state == stExecute);
	// counter already sits at zero after any earlier shift
	assign load = (state == stExecute) && seq.ctrl.isShift && (seq.shamt != '0);
	assign step = (state == stShift) && !shiftDone;
	// err takes the writeback slot
	assign writeEn = (state == stWrite) && seq.ctrl.regWrite;
	assign err = (state == stWrite) && seq.ctrl.illegal;

	// once halted no new instruction is accepted
	noAckAfterHalt: assert property (@(posedge clk) disable iff (rst)
		(!$past(rst) && $past(halt)) |-> !$rose(instrAck));

endmodule

`default_nettype wire

// ==== decodeCore.sv ====
`timescale 1ns/10ps
`default_nettype none

module decodeCore (
	input logic clk,
	input logic rst,
	input logic instrReq,
	input logic [15:0] instr,
	output logic instrAck,
	output logic wbEn,
	output logic [2:0] wbReg,
	output logic [15:0] wbData,
	output logic err,
	output logic halt
);

	decodeIf dec ();

	logic [cpuPkg::dataWidth-1:0] instrReg;
	logic [cpuPkg::dataWidth-1:0] result;
	logic latchInstr;
	logic start;
	logic step;
	logic load;
	logic shiftDone;
	logic writeEn;

	// instruction held for the whole retirement
	always_ff @(posedge clk) begin
		if (latchInstr) begin
			instrReg <= instr;
		end
	end

	coreSequencer u_coreSequencer (
		.clk(clk), .rst(rst),
		.instrReq(instrReq), .instrAck(instrAck), .latchInstr(latchInstr),
		.seq(dec.sequencer),
		.start(start), .step(step), .load(load), .shiftDone(shiftDone),
		.writeEn(writeEn), .err(err), .halt(halt)
	);

	decodeInstruction u_decodeInstruction (
		.clk(clk), .rst(rst), .instruction(instrReg),
		.writeData(result), .writeRegister(dec.destReg), .writeEn(writeEn),
		.dec(dec.producer)
	);

	execUnit u_execUnit (
		.clk(clk), .rst(rst), .start(start), .step(step),
		.dec(dec.execute), .result(result)
	);

	shiftCounter u_shiftCounter (
		.clk(clk), .rst(rst), .load(load), .amount(dec.shamt),
		.step(step), .done(shiftDone)
	);

	// writeback report mirrors the register file write
	assign wbEn = writeEn;
	assign wbReg = dec.destReg;
	assign wbData = result;

endmodule

`default_nettype wire

// ==== coreChecker.sv ====
`timescale 1ns/10ps
`default_nettype none

module coreChecker (
	input logic clk,
	input logic rst,
	input logic instrAck,
	input logic wbEn,
	input logic [2:0] wbReg,
	input logic [15:0] wbData,
	input logic err,
	input logic halt,
	input logic expValid,
	input logic [2:0] expKind,
	input logic [2:0] expReg,
	input logic [15:0] expData,
	input logic [4:0] expLatency,
	input logic drainCheck,
	output int checkCount,
	output int errorCount
);

	// {kind, reg, data, latency}
	logic [26:0] expQ [$];
	logic [26:0] entry;
	logic [2:0] observed;
	logic prevAck = 1'b0;
	logic prevHalt = 1'b0;
	logic haltSeen = 1'b0;
	int ackCycles = 0;
	int checks = 0;
	int errors = 0;

	assign checkCount = checks;
	assign errorCount = errors;

	function automatic string kindName(input logic [2:0] kind);
		case (kind)
			3'b001: return "wbEn";
			3'b010: return "err";
			3'b100: return "halt";
			default: return "combined";
		endcase
	endfunction

	task automatic compareValue(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		checks++;
		if (expected !== actual) begin
			$display("ERROR at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic checkEvent();
		if (expQ.size() == 0) begin
			$display("unexpected %s event at %0d ns, nothing was expected",
				kindName(observed), $time);
			errors++;
		end else begin
			entry = expQ.pop_front();
			checks++;
			if (observed != entry[26:24]) begin
				$display("expected a %s event at %0d ns but saw %s",
					kindName(entry[26:24]), $time, kindName(observed));
				errors++;
			end else if (observed != 3'b100) begin
				// cycles counted from the instrAck rise
				compareValue("ackToEventCycles", 16'(entry[4:0]), 16'(ackCycles));
				if (wbEn) begin
					compareValue("wbReg", 16'(entry[23:21]), 16'(wbReg));
					compareValue("wbData", entry[20:5], wbData);
				end
			end
		end
	endtask

	// mid-cycle sampling, everything settled
	always @(negedge clk) begin
		if (expValid) begin
			expQ.push_back({expKind, expReg, expData, expLatency});
		end
		if (rst) begin
			// quiet outputs under reset
			compareValue("instrAck", 16'h0000, 16'(instrAck));
			compareValue("wbEn", 16'h0000, 16'(wbEn));
			compareValue("err", 16'h0000, 16'(err));
			compareValue("halt", 16'h0000, 16'(halt));
		end else begin
			if (instrAck && !prevAck) begin
				ackCycles = 0;
			end else begin
				ackCycles++;
			end
			if (haltSeen && instrAck && !prevAck) begin
				$display("instrAck rose at %0d ns after the core had halted", $time);
				errors++;
			end
			if (haltSeen && !halt) begin
				$display("halt dropped at %0d ns before any reset", $time);
				errors++;
			end
			observed = {halt && !prevHalt, err, wbEn};
			if (observed != 3'b000) begin
				checkEvent();
			end
			if (halt) begin
				haltSeen = 1'b1;
			end
		end
		// end of a test, nothing may be left over
		if (drainCheck) begin
			checks++;
			if (expQ.size() != 0) begin
				$display("%0d expected events never happened by %0d ns", expQ.size(), $time);
				errors++;
				expQ.delete();
			end
		end
		prevAck = instrAck;
		prevHalt = halt;
	end

endmodule

`default_nettype wire

// ==== tb_decodeCore.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_decodeCore;

	localparam int resetCycles = 16;
	// every issued instruction, the late request after HALT included
	localparam int totalInstr = 8 + 60 + 16 + 30 + 20 + 2;

	logic clk;
	logic rst;
	logic instrReq;
	logic [15:0] instr;
	logic instrAck;
	logic wbEn;
	logic [2:0] wbReg;
	logic [15:0] wbData;
	logic err;
	logic halt;
	// expectations for the checker, kind is one-hot {halt, err, wbEn}
	logic expValid;
	logic [2:0] expKind;
	logic [2:0] expReg;
	logic [15:0] expData;
	logic [4:0] expLatency;
	logic drainCheck;
	int checkCount;
	int errorCount;
	int testErrorBase;
	logic [31:0] rngState;
	// reference register file
	logic [15:0] modelRegs [8];

	decodeCore u_decodeCore (
		.clk(clk), .rst(rst), .instrReq(instrReq), .instr(instr),
		.instrAck(instrAck), .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData),
		.err(err), .halt(halt)
	);

	coreChecker u_coreChecker (
		.clk(clk), .rst(rst), .instrAck(instrAck), .wbEn(wbEn), .wbReg(wbReg),
		.wbData(wbData), .err(err), .halt(halt),
		.expValid(expValid), .expKind(expKind), .expReg(expReg), .expData(expData),
		.expLatency(expLatency), .drainCheck(drainCheck),
		.checkCount(checkCount), .errorCount(errorCount)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// lcg step, middle bits are the better ones
	function automatic logic [15:0] nextRand();
		rngState = rngState * 32'd1103515245 + 32'd12345;
		return rngState[30:15];
	endfunction

	function automatic logic [15:0] signExtend5(input logic [4:0] v);
		return {{11{v[4]}}, v};
	endfunction

	function automatic logic [15:0] signExtend8(input logic [7:0] v);
		return {{8{v[7]}}, v};
	endfunction

	function automatic logic isLegal(input logic [4:0] op);
		return op inside {cpuPkg::opAlu, cpuPkg::opAddi, cpuPkg::opAndni, cpuPkg::opSlli,
			cpuPkg::opSrli, cpuPkg::opLbi, cpuPkg::opSlbi, cpuPkg::opNop, cpuPkg::opHalt};
	endfunction

	// inputs change 5 ns after the edge
	task automatic waitCycle();
		@(posedge clk);
		#5;
	endtask

	task automatic pushExpect(input logic [2:0] kind, input logic [2:0] regIdx,
			input logic [15:0] data, input logic [4:0] latency);
		expValid = 1'b1;
		expKind = kind;
		expReg = regIdx;
		expData = data;
		expLatency = latency;
		waitCycle();
		expValid = 1'b0;
	endtask

	// one full four-phase transfer
	task automatic issueInstr(input logic [15:0] word);
		instr = word;
		instrReq = 1'b1;
		while (!instrAck) begin
			waitCycle();
		end
		instrReq = 1'b0;
		// ack drops only once the instruction has retired
		while (instrAck) begin
			waitCycle();
		end
	endtask

	task automatic runWrite(input logic [15:0] word, input logic [2:0] dest,
			input logic [15:0] value, input logic [4:0] latency);
		pushExpect(3'b001, dest, value, latency);
		issueInstr(word);
		modelRegs[dest] = value;
	endtask

	task automatic endTest(input int num, input string name, input int count);
		drainCheck = 1'b1;
		waitCycle();
		drainCheck = 1'b0;
		$display("test %0d %s: %0d instructions, %0d errors",
			num, name, count, errorCount - testErrorBase);
		testErrorBase = errorCount;
	endtask

	// each register read once before its first write
	task automatic zeroRegTest();
		logic [15:0] r;
		for (int i = 0; i < 8; i++) begin
			r = nextRand();
			runWrite({cpuPkg::opAddi, 3'(i), 3'(i), r[4:0]}, 3'(i),
				modelRegs[i] + signExtend5(r[4:0]), 5'd3);
		end
		endTest(1, "reset state and zero registers", 8);
	endtask

	task automatic aluTest();
		logic [15:0] r;
		logic [2:0] rs;
		logic [2:0] rt;
		logic [2:0] rd;
		logic [4:0] imm5;
		logic [2:0] kind;
		logic [15:0] value;
		for (int i = 0; i < 60; i++) begin
			r = nextRand();
			rs = r[2:0];
			rt = r[5:3];
			rd = r[8:6];
			imm5 = r[13:9];
			r = nextRand();
			kind = r[2:0] % 3'd6;
			if (kind < 3'd4) begin
				// funct 00 add, 01 sub, 10 and, 11 xor
				case (kind[1:0])
					2'b00: value = modelRegs[rs] + modelRegs[rt];
					2'b01: value = modelRegs[rs] - modelRegs[rt];
					2'b10: value = modelRegs[rs] & modelRegs[rt];
					default: value = modelRegs[rs] ^ modelRegs[rt];
				endcase
				runWrite({cpuPkg::opAlu, rs, rt, rd, kind[1:0]}, rd, value, 5'd3);
			end else if (kind == 3'd4) begin
				value = modelRegs[rs] + signExtend5(imm5);
				runWrite({cpuPkg::opAddi, rs, rt, imm5}, rt, value, 5'd3);
			end else begin
				value = modelRegs[rs] & ~{11'b0, imm5};
				runWrite({cpuPkg::opAndni, rs, rt, imm5}, rt, value, 5'd3);
			end
		end
		endTest(2, "random R-type, ADDI and ANDNI", 60);
	endtask

	// LBI then SLBI gives the full word
	task automatic constantTest();
		logic [15:0] r;
		logic [2:0] rs;
		for (int i = 0; i < 8; i++) begin
			r = nextRand();
			rs = r[2:0];
			runWrite({cpuPkg::opLbi, rs, r[15:8]}, rs, signExtend8(r[15:8]), 5'd3);
			r = nextRand();
			runWrite({cpuPkg::opSlbi, rs, r[7:0]}, rs,
				(modelRegs[rs] << 8) | {8'b0, r[7:0]}, 5'd3);
		end
		endTest(3, "LBI and SLBI constants", 16);
	endtask

	// one extra cycle per shift step
	task automatic shiftTest();
		logic [15:0] r;
		logic [2:0] rs;
		logic [2:0] rt;
		logic [3:0] amt;
		for (int i = 0; i < 30; i++) begin
			r = nextRand();
			rs = r[2:0];
			rt = r[5:3];
			amt = r[9:6];
			if (r[11]) begin
				runWrite({cpuPkg::opSrli, rs, rt, r[10], amt}, rt, modelRegs[rs] >> amt,
					5'd3 + {1'b0, amt});
			end else begin
				runWrite({cpuPkg::opSlli, rs, rt, r[10], amt}, rt, modelRegs[rs] << amt,
					5'd3 + {1'b0, amt});
			end
		end
		endTest(4, "SLLI and SRLI", 30);
	endtask

	task automatic illegalTest();
		logic [15:0] r;
		logic [4:0] op;
		for (int i = 0; i < 20; i++) begin
			r = nextRand();
			op = r[15:11];
			if (r[0]) begin
				// NOP retires with no event
				issueInstr({cpuPkg::opNop, r[10:0]});
			end else begin
				while (isLegal(op)) begin
					r = nextRand();
					op = r[15:11];
				end
				// err in the writeback slot, model untouched
				pushExpect(3'b010, 3'b000, 16'h0000, 5'd3);
				issueInstr({op, r[10:0]});
			end
		end
		endTest(5, "illegal opcodes and NOP", 20);
	endtask

	task automatic haltTest();
		logic [15:0] r;
		r = nextRand();
		pushExpect(3'b100, 3'b000, 16'h0000, 5'd0);
		issueInstr({cpuPkg::opHalt, r[10:0]});
		// late request, the checker flags any ack
		instr = {cpuPkg::opAddi, r[10:0]};
		instrReq = 1'b1;
		repeat (40) begin
			waitCycle();
		end
		instrReq = 1'b0;
		endTest(6, "halt and late request", 2);
	endtask

	initial begin
		rst = 1'b1;
		instrReq = 1'b0;
		instr = 16'h0000;
		expValid = 1'b0;
		expKind = 3'b000;
		expReg = 3'b000;
		expData = 16'h0000;
		expLatency = 5'd0;
		drainCheck = 1'b0;
		testErrorBase = 0;
		rngState = 32'd80101;
		for (int i = 0; i < 8; i++) begin
			modelRegs[i] = 16'h0000;
		end
		repeat (resetCycles) begin
			@(posedge clk);
		end
		#5;
		rst = 1'b0;
		zeroRegTest();
		aluTest();
		constantTest();
		shiftTest();
		illegalTest();
		haltTest();
		$display("summary: %0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	// forty cycles per instruction is far above the slowest shift
	initial begin
		repeat (resetCycles + 40 * totalInstr) begin
			@(posedge clk);
		end
		$display("watchdog expired, the core stopped answering the handshake");
		$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
cpuPkg.sv
decodeIf.sv
controlDecode.sv
regFile.sv
immExtend.sv
decodeInstruction.sv
execUnit.sv
shiftCounter.sv
coreSequencer.sv
decodeCore.sv
coreChecker.sv
tb_decodeCore.sv

// ==== Makefile ====
.PHONY: all lint clean

all:
	verilator --binary --timing --assert -j 0 --top-module tb_decodeCore -f flist.f
	./obj_dir/Vtb_decodeCore | awk '{ print } /^All checks passed$$/ { ok = 1 } END { exit !ok }'

lint:
	verilator --lint-only --timing --assert --top-module tb_decodeCore -f flist.f

clean:
	rm -rf obj_dir
